// ==== list.f ====
source/cpu_params_pkg.sv
source/uop_types_pkg.sv
source/int_rs.sv
source/fu_alu.sv
source/int_exec_top.sv
tests/int_exec_tb.sv

// ==== source/cpu_params_pkg.sv ====
package cpu_params_pkg;

    // datapath width.
    localparam int xlen = 32;

    // physical register tag, 64 registers.
    localparam int phy_reg_bits = 6;

    // architectural register index.
    localparam int arch_reg_bits = 5;

    // reorder buffer id width.
    localparam int rob_id_bits = 5;

    // integer reservation station size.
    localparam int int_rs_depth = 8;
    localparam int int_rs_idx_bits = 3; // log2 of int_rs_depth.

endpackage

// ==== source/fu_alu.sv ====
module fu_alu
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       int_rs_valid,
    output logic                       fu_alu_ready,
    input  logic [rob_id_bits-1:0]     rob_id,
    input  logic [arch_reg_bits-1:0]   rd_arch,
    input  logic [phy_reg_bits-1:0]    rd_phy,
    input  logic [xlen-1:0]            pc,
    input  logic [xlen-1:0]            imm,
    input  alu_op_t                    fu_opcode,
    input  op1_sel_t                   op1_sel,
    input  op2_sel_t                   op2_sel,
    input  logic [xlen-1:0]            rs1_value,
    input  logic [xlen-1:0]            rs2_value,
    output logic                       cdb_valid,
    output logic [rob_id_bits-1:0]     cdb_rob_id,
    output logic [arch_reg_bits-1:0]   cdb_rd_arch,
    output logic [phy_reg_bits-1:0]    cdb_rd_phy,
    output logic [xlen-1:0]            cdb_rd_value
);

    logic                       alu_valid;
    logic [rob_id_bits-1:0]     rob_id_q;
    logic [arch_reg_bits-1:0]   rd_arch_q;
    logic [phy_reg_bits-1:0]    rd_phy_q;
    logic [xlen-1:0]            pc_q;
    logic [xlen-1:0]            imm_q;
    alu_op_t                    opcode_q;
    op1_sel_t                   op1_sel_q;
    op2_sel_t                   op2_sel_q;
    logic [xlen-1:0]            rs1_q;
    logic [xlen-1:0]            rs2_q;

    logic [xlen-1:0]            a;
    logic [xlen-1:0]            b;
    logic [xlen-1:0]            alu_out;

    // cdb never stalls, so neither do we.
    assign fu_alu_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else if (fu_alu_ready) begin
            alu_valid <= int_rs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (int_rs_valid && fu_alu_ready) begin
            rob_id_q  <= rob_id;
            rd_arch_q <= rd_arch;
            rd_phy_q  <= rd_phy;
            pc_q      <= pc;
            imm_q     <= imm;
            opcode_q  <= fu_opcode;
            op1_sel_q <= op1_sel;
            op2_sel_q <= op2_sel;
            rs1_q     <= rs1_value;
            rs2_q     <= rs2_value;
        end
    end

    always_comb begin
        unique case (op1_sel_q)
            op1_rs1:  a = rs1_q;
            op1_zero: a = '0;
            op1_pc:   a = pc_q;
            default:  a = '0;
        endcase
        unique case (op2_sel_q)
            op2_rs2:  b = rs2_q;
            op2_zero: b = '0;
            op2_imm:  b = imm_q;
            default:  b = '0;
        endcase
    end

    always_comb begin
        unique case (opcode_q)
            alu_add:  alu_out = a + b;
            alu_sub:  alu_out = a - b;
            alu_sll:  alu_out = a << b[4:0];
            alu_srl:  alu_out = a >> b[4:0];
            alu_sra:  alu_out = unsigned'($signed(a) >>> b[4:0]);
            alu_xor:  alu_out = a ^ b;
            alu_or:   alu_out = a | b;
            alu_and:  alu_out = a & b;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, a < b};
            default:  alu_out = '0;
        endcase
    end

    // cdb broadcast register.
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            cdb_rob_id   <= rob_id_q;
            cdb_rd_arch  <= rd_arch_q;
            cdb_rd_phy   <= rd_phy_q;
            cdb_rd_value <= alu_out;
        end
    end

    a_opcode_known: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> !$isunknown(opcode_q))
        else $error("fu_alu: unknown opcode in execute stage");

endmodule

// ==== source/int_exec_top.sv ====
module int_exec_top
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispatch_valid,
    output logic                       dispatch_ready,
    input  logic [rob_id_bits-1:0]     rob_id,
    input  logic [arch_reg_bits-1:0]   rd_arch,
    input  logic [phy_reg_bits-1:0]    rd_phy,
    input  logic [xlen-1:0]            pc,
    input  logic [xlen-1:0]            imm,
    input  alu_op_t                    fu_opcode,
    input  op1_sel_t                   op1_sel,
    input  op2_sel_t                   op2_sel,
    input  logic [phy_reg_bits-1:0]    rs1_phy,
    input  logic                       rs1_ready,
    input  logic [xlen-1:0]            rs1_value,
    input  logic [phy_reg_bits-1:0]    rs2_phy,
    input  logic                       rs2_ready,
    input  logic [xlen-1:0]            rs2_value,
    output logic                       cdb_valid,
    output logic [rob_id_bits-1:0]     cdb_rob_id,
    output logic [arch_reg_bits-1:0]   cdb_rd_arch,
    output logic [phy_reg_bits-1:0]    cdb_rd_phy,
    output logic [xlen-1:0]            cdb_rd_value
);

    logic                       issue_valid;
    logic                       fu_alu_ready;
    logic [rob_id_bits-1:0]     issue_rob_id;
    logic [arch_reg_bits-1:0]   issue_rd_arch;
    logic [phy_reg_bits-1:0]    issue_rd_phy;
    logic [xlen-1:0]            issue_pc;
    logic [xlen-1:0]            issue_imm;
    alu_op_t                    issue_fu_opcode;
    op1_sel_t                   issue_op1_sel;
    op2_sel_t                   issue_op2_sel;
    logic [xlen-1:0]            issue_rs1_value;
    logic [xlen-1:0]            issue_rs2_value;

    // cdb loops back into the station for wakeup.
    int_rs u_int_rs (
        .clk, .rst, .dispatch_valid, .dispatch_ready,
        .rob_id, .rd_arch, .rd_phy, .pc, .imm, .fu_opcode, .op1_sel, .op2_sel,
        .rs1_phy, .rs1_ready, .rs1_value, .rs2_phy, .rs2_ready, .rs2_value,
        .issue_valid, .fu_alu_ready,
        .issue_rob_id, .issue_rd_arch, .issue_rd_phy, .issue_pc, .issue_imm,
        .issue_fu_opcode, .issue_op1_sel, .issue_op2_sel,
        .issue_rs1_value, .issue_rs2_value,
        .cdb_valid, .cdb_rd_phy, .cdb_rd_value
    );

    fu_alu u_fu_alu (
        .clk, .rst,
        .int_rs_valid (issue_valid),
        .fu_alu_ready,
        .rob_id       (issue_rob_id),
        .rd_arch      (issue_rd_arch),
        .rd_phy       (issue_rd_phy),
        .pc           (issue_pc),
        .imm          (issue_imm),
        .fu_opcode    (issue_fu_opcode),
        .op1_sel      (issue_op1_sel),
        .op2_sel      (issue_op2_sel),
        .rs1_value    (issue_rs1_value),
        .rs2_value    (issue_rs2_value),
        .cdb_valid, .cdb_rob_id, .cdb_rd_arch, .cdb_rd_phy, .cdb_rd_value
    );

endmodule

// ==== source/int_rs.sv ====
module int_rs
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispatch_valid,
    output logic                       dispatch_ready,
    input  logic [rob_id_bits-1:0]     rob_id,
    input  logic [arch_reg_bits-1:0]   rd_arch,
    input  logic [phy_reg_bits-1:0]    rd_phy,
    input  logic [xlen-1:0]            pc,
    input  logic [xlen-1:0]            imm,
    input  alu_op_t                    fu_opcode,
    input  op1_sel_t                   op1_sel,
    input  op2_sel_t                   op2_sel,
    input  logic [phy_reg_bits-1:0]    rs1_phy,
    input  logic                       rs1_ready,
    input  logic [xlen-1:0]            rs1_value,
    input  logic [phy_reg_bits-1:0]    rs2_phy,
    input  logic                       rs2_ready,
    input  logic [xlen-1:0]            rs2_value,
    output logic                       issue_valid,
    input  logic                       fu_alu_ready,
    output logic [rob_id_bits-1:0]     issue_rob_id,
    output logic [arch_reg_bits-1:0]   issue_rd_arch,
    output logic [phy_reg_bits-1:0]    issue_rd_phy,
    output logic [xlen-1:0]            issue_pc,
    output logic [xlen-1:0]            issue_imm,
    output alu_op_t                    issue_fu_opcode,
    output op1_sel_t                   issue_op1_sel,
    output op2_sel_t                   issue_op2_sel,
    output logic [xlen-1:0]            issue_rs1_value,
    output logic [xlen-1:0]            issue_rs2_value,
    input  logic                       cdb_valid,
    input  logic [phy_reg_bits-1:0]    cdb_rd_phy,
    input  logic [xlen-1:0]            cdb_rd_value
);

    logic [int_rs_depth-1:0]    entry_valid;
    logic [int_rs_depth-1:0]    rs1_rdy;
    logic [int_rs_depth-1:0]    rs2_rdy;

    logic [rob_id_bits-1:0]     e_rob_id    [int_rs_depth];
    logic [arch_reg_bits-1:0]   e_rd_arch   [int_rs_depth];
    logic [phy_reg_bits-1:0]    e_rd_phy    [int_rs_depth];
    logic [xlen-1:0]            e_pc        [int_rs_depth];
    logic [xlen-1:0]            e_imm       [int_rs_depth];
    alu_op_t                    e_opcode    [int_rs_depth];
    op1_sel_t                   e_op1_sel   [int_rs_depth];
    op2_sel_t                   e_op2_sel   [int_rs_depth];
    logic [phy_reg_bits-1:0]    e_rs1_phy   [int_rs_depth];
    logic [phy_reg_bits-1:0]    e_rs2_phy   [int_rs_depth];
    logic [xlen-1:0]            e_rs1_value [int_rs_depth];
    logic [xlen-1:0]            e_rs2_value [int_rs_depth];

    // age = number of younger valid entries, so oldest has the largest.
    logic [int_rs_idx_bits-1:0] e_age       [int_rs_depth];
    logic [int_rs_idx_bits-1:0] age_next    [int_rs_depth];

    logic [int_rs_idx_bits-1:0] alloc_idx;
    logic [int_rs_idx_bits-1:0] issue_idx;
    logic [int_rs_idx_bits-1:0] issue_age;
    logic                       dispatch_fire;
    logic                       issue_fire;

    logic                       new_rs1_rdy;
    logic                       new_rs2_rdy;
    logic [xlen-1:0]            new_rs1_value;
    logic [xlen-1:0]            new_rs2_value;

    assign dispatch_ready = ~&entry_valid;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign issue_fire     = issue_valid && fu_alu_ready;

    // lowest free slot.
    always_comb begin
        alloc_idx = '0;
        for (int i = int_rs_depth - 1; i >= 0; i--) begin
            if (!entry_valid[i]) alloc_idx = int_rs_idx_bits'(i);
        end
    end

    // unused sources count as ready; a same-cycle broadcast beats dispatch.
    always_comb begin
        new_rs1_rdy   = rs1_ready || (op1_sel != op1_rs1);
        new_rs2_rdy   = rs2_ready || (op2_sel != op2_rs2);
        new_rs1_value = rs1_value;
        new_rs2_value = rs2_value;
        if (!new_rs1_rdy && cdb_valid && (cdb_rd_phy == rs1_phy)) begin
            new_rs1_rdy   = 1'b1;
            new_rs1_value = cdb_rd_value;
        end
        if (!new_rs2_rdy && cdb_valid && (cdb_rd_phy == rs2_phy)) begin
            new_rs2_rdy   = 1'b1;
            new_rs2_value = cdb_rd_value;
        end
    end

    // oldest ready entry.
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        issue_age   = '0;
        for (int i = 0; i < int_rs_depth; i++) begin
            if (entry_valid[i] && rs1_rdy[i] && rs2_rdy[i] &&
                (!issue_valid || (e_age[i] > issue_age))) begin
                issue_valid = 1'b1;
                issue_idx   = int_rs_idx_bits'(i);
                issue_age   = e_age[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < int_rs_depth; i++) begin
            age_next[i] = e_age[i];
            if (dispatch_fire) age_next[i] = age_next[i] + 1'b1;
            // a younger entry leaving.
            if (issue_fire && (e_age[i] > issue_age)) age_next[i] = age_next[i] - 1'b1;
        end
    end

    assign issue_rob_id    = e_rob_id[issue_idx];
    assign issue_rd_arch   = e_rd_arch[issue_idx];
    assign issue_rd_phy    = e_rd_phy[issue_idx];
    assign issue_pc        = e_pc[issue_idx];
    assign issue_imm       = e_imm[issue_idx];
    assign issue_fu_opcode = e_opcode[issue_idx];
    assign issue_op1_sel   = e_op1_sel[issue_idx];
    assign issue_op2_sel   = e_op2_sel[issue_idx];
    assign issue_rs1_value = e_rs1_value[issue_idx];
    assign issue_rs2_value = e_rs2_value[issue_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            if (issue_fire) entry_valid[issue_idx] <= 1'b0;
            if (dispatch_fire) entry_valid[alloc_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < int_rs_depth; i++) begin
            if (dispatch_fire && (alloc_idx == int_rs_idx_bits'(i))) begin
                e_rob_id[i]    <= rob_id;
                e_rd_arch[i]   <= rd_arch;
                e_rd_phy[i]    <= rd_phy;
                e_pc[i]        <= pc;
                e_imm[i]       <= imm;
                e_opcode[i]    <= fu_opcode;
                e_op1_sel[i]   <= op1_sel;
                e_op2_sel[i]   <= op2_sel;
                e_rs1_phy[i]   <= rs1_phy;
                e_rs2_phy[i]   <= rs2_phy;
                rs1_rdy[i]     <= new_rs1_rdy;
                rs2_rdy[i]     <= new_rs2_rdy;
                e_rs1_value[i] <= new_rs1_value;
                e_rs2_value[i] <= new_rs2_value;
                e_age[i]       <= '0; // youngest.
            end else begin
                e_age[i] <= age_next[i];
                if (cdb_valid && !rs1_rdy[i] && (e_rs1_phy[i] == cdb_rd_phy)) begin
                    rs1_rdy[i]     <= 1'b1; // wakeup.
                    e_rs1_value[i] <= cdb_rd_value;
                end
                if (cdb_valid && !rs2_rdy[i] && (e_rs2_phy[i] == cdb_rd_phy)) begin
                    rs2_rdy[i]     <= 1'b1;
                    e_rs2_value[i] <= cdb_rd_value;
                end
            end
        end
    end

    // never overwrite a live entry.
    a_no_write_live: assert property (@(posedge clk) disable iff (rst)
        dispatch_fire |-> !entry_valid[alloc_idx])
        else $error("int_rs: dispatch accepted into a valid entry while full");

    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> entry_valid[issue_idx] && rs1_rdy[issue_idx] && rs2_rdy[issue_idx])
        else $error("int_rs: issued entry not valid or not ready");

endmodule

// ==== source/uop_types_pkg.sv ====
package uop_types_pkg;

    // integer alu operations.
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_srl  = 4'd3,
        alu_sra  = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_slt  = 4'd8, // signed compare.
        alu_sltu = 4'd9  // unsigned compare.
    } alu_op_t;

    // source of operand a.
    typedef enum logic [1:0] {
        op1_rs1  = 2'd0,
        op1_zero = 2'd1,
        op1_pc   = 2'd2
    } op1_sel_t;

    // source of operand b.
    typedef enum logic [1:0] {
        op2_rs2  = 2'd0,
        op2_zero = 2'd1,
        op2_imm  = 2'd2
    } op2_sel_t;

endpackage

// ==== tests/int_exec_cases.txt ====
// rob arch phy pc imm op op1_sel op2_sel rs1_phy rs1_rdy rs1_val rs2_phy rs2_rdy rs2_val gap exp
// ops: 0 add 1 sub 2 sll 3 srl 4 sra 5 xor 6 or 7 and 8 slt 9 sltu; sel: 0 reg 1 zero 2 pc/imm
// every opcode, isolated
00 01 10 00000000 00000000 0 0 0 00 1 7fffffff 00 1 00000001 03 80000000
01 02 11 00000000 00000000 1 0 0 00 1 00000000 00 1 00000001 03 ffffffff
02 03 12 00000000 00000000 2 0 0 00 1 0000000f 00 1 00000024 03 000000f0
03 04 13 00000000 00000000 3 0 0 00 1 80000000 00 1 0000001f 03 00000001
04 05 14 00000000 00000000 4 0 0 00 1 80000000 00 1 00000004 03 f8000000
05 06 15 00000000 00000000 4 0 0 00 1 fffffff0 00 1 0000003f 03 ffffffff
06 07 16 00000000 00000000 5 0 0 00 1 a5a5a5a5 00 1 ffff0000 03 5a5aa5a5
07 08 17 00000000 00000000 6 0 0 00 1 12340000 00 1 00005678 03 12345678
08 09 18 00000000 00000000 7 0 0 00 1 f0f0f0f0 00 1 3c3c3c3c 03 30303030
09 0a 19 00000000 00000000 8 0 0 00 1 ffffffff 00 1 00000001 03 00000001
0a 0b 1a 00000000 00000000 9 0 0 00 1 ffffffff 00 1 00000001 03 00000000
// operand selects
0b 0c 1b 00001000 00000014 0 2 2 3f 0 deadbeef 3f 0 deadbeef 03 00001014
0c 0d 1c 00000000 fffff800 0 1 2 00 1 12345678 3f 0 deadbeef 03 fffff800
0d 0e 1d 00000000 00000000 6 0 1 00 1 13579bdf 00 1 ffffffff 03 13579bdf
0e 0f 1e 00002000 00000000 1 2 0 3f 0 deadbeef 00 1 00000010 03 00001ff0
// dependency chain
0f 10 1f 00000000 00000005 0 0 2 00 1 00000010 3f 0 deadbeef 04 00000015
10 11 20 00000000 00000000 1 0 0 1f 0 deadbeef 00 1 00000003 00 00000012
11 12 21 00000000 00000000 2 0 0 00 1 00000001 20 0 deadbeef 00 00040000
12 13 22 00000000 00000000 0 0 0 1f 0 deadbeef 21 0 deadbeef 00 00040015
// full station, four producers then nine consumers
13 14 23 00000000 00000001 0 0 2 00 1 00000001 3f 0 deadbeef 09 00000002
14 15 24 00000000 00000001 0 0 2 23 0 deadbeef 3f 0 deadbeef 00 00000003
15 16 25 00000000 00000001 0 0 2 24 0 deadbeef 3f 0 deadbeef 00 00000004
16 17 26 00000000 00000001 0 0 2 25 0 deadbeef 3f 0 deadbeef 00 00000005
17 18 27 00000000 00000100 0 0 2 26 0 deadbeef 3f 0 deadbeef 00 00000105
18 19 28 00000000 00000001 1 0 2 26 0 deadbeef 3f 0 deadbeef 00 00000004
19 1a 29 00000000 000000ff 5 0 2 26 0 deadbeef 3f 0 deadbeef 00 000000fa
1a 1b 2a 00000000 00000030 6 0 2 26 0 deadbeef 3f 0 deadbeef 00 00000035
1b 1c 2b 00000000 00000004 7 0 2 26 0 deadbeef 3f 0 deadbeef 00 00000004
1c 1d 2c 00000000 00000008 2 0 2 26 0 deadbeef 3f 0 deadbeef 00 00000500
1d 1e 2d 00000000 00000000 8 0 0 00 1 00000004 26 0 deadbeef 00 00000001
1e 1f 2e 00000000 00000000 0 0 0 00 1 00000010 26 0 deadbeef 00 00000015
1f 01 2f 00000000 00000001 0 0 2 27 0 deadbeef 3f 0 deadbeef 00 00000106

// ==== tests/int_exec_tb.sv ====
module int_exec_tb
    import cpu_params_pkg::*;
    import uop_types_pkg::*;
();

    localparam int clk_period = 100;
    localparam int case_words = 16;
    localparam int max_cases  = 32;
    localparam int rob_count  = 1 << rob_id_bits;
    localparam int phy_count  = 1 << phy_reg_bits;

    logic                     clk;
    logic                     rst;
    logic                     dispatch_valid;
    logic                     dispatch_ready;
    logic [rob_id_bits-1:0]   rob_id;
    logic [arch_reg_bits-1:0] rd_arch;
    logic [phy_reg_bits-1:0]  rd_phy;
    logic [xlen-1:0]          pc;
    logic [xlen-1:0]          imm;
    alu_op_t                  fu_opcode;
    op1_sel_t                 op1_sel;
    op2_sel_t                 op2_sel;
    logic [phy_reg_bits-1:0]  rs1_phy;
    logic                     rs1_ready;
    logic [xlen-1:0]          rs1_value;
    logic [phy_reg_bits-1:0]  rs2_phy;
    logic                     rs2_ready;
    logic [xlen-1:0]          rs2_value;
    logic                     cdb_valid;
    logic [rob_id_bits-1:0]   cdb_rob_id;
    logic [arch_reg_bits-1:0] cdb_rd_arch;
    logic [phy_reg_bits-1:0]  cdb_rd_phy;
    logic [xlen-1:0]          cdb_rd_value;

    // one row of 16 words per micro-op.
    logic [31:0]              case_mem [max_cases*case_words];
    int                       n_cases;
    int                       total_gap;
    bit                       cases_loaded;
    longint                   watchdog_limit;

    // scoreboard, indexed by rob id.
    logic [xlen-1:0]          exp_value   [rob_count];
    logic [arch_reg_bits-1:0] exp_arch    [rob_count];
    logic [phy_reg_bits-1:0]  exp_phy     [rob_count];
    bit                       pending     [rob_count];
    bit                       lat_check   [rob_count];
    bit                       wait1       [rob_count];
    bit                       wait2       [rob_count];
    logic [phy_reg_bits-1:0]  tag1        [rob_count];
    logic [phy_reg_bits-1:0]  tag2        [rob_count];
    time                      accept_time [rob_count];
    int                       case_of_rob [rob_count];
    bit                       phy_seen    [phy_count];

    int                       outstanding;
    int                       pass_count;
    int                       fail_count;
    bit                       stall_seen;
    bit                       full_bad;
    logic [31:0]              rng;

    int_exec_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_test(input string name, input bit bad);
        if (bad) begin
            fail_count++;
            $display("%s: fail", name);
        end else begin
            pass_count++;
            $display("%s: pass", name);
        end
    endtask

    task automatic drive_case(input int c);
        int b;
        b         = c * case_words;
        rob_id    = case_mem[b][rob_id_bits-1:0];
        rd_arch   = case_mem[b+1][arch_reg_bits-1:0];
        rd_phy    = case_mem[b+2][phy_reg_bits-1:0];
        pc        = case_mem[b+3];
        imm       = case_mem[b+4];
        fu_opcode = alu_op_t'(case_mem[b+5][3:0]);
        op1_sel   = op1_sel_t'(case_mem[b+6][1:0]);
        op2_sel   = op2_sel_t'(case_mem[b+7][1:0]);
        rs1_phy   = case_mem[b+8][phy_reg_bits-1:0];
        rs1_ready = case_mem[b+9][0];
        rs1_value = case_mem[b+10];
        rs2_phy   = case_mem[b+11][phy_reg_bits-1:0];
        rs2_ready = case_mem[b+12][0];
        rs2_value = case_mem[b+13];
        dispatch_valid = 1'b1;
    endtask

    // called on the falling edge before the edge that takes the micro-op.
    task automatic record_accept(input int c);
        int b;
        int r;
        b = c * case_words;
        r = case_mem[b][rob_id_bits-1:0];
        if (pending[r]) begin
            $display("rob id %0d was dispatched again while still outstanding", r);
            fail_count++;
        end
        exp_value[r] = case_mem[b+15];
        exp_arch[r]  = case_mem[b+1][arch_reg_bits-1:0];
        exp_phy[r]   = case_mem[b+2][phy_reg_bits-1:0];
        // a source only waits if its select uses it.
        wait1[r] = (case_mem[b+6][1:0] == op1_rs1) && !case_mem[b+9][0];
        wait2[r] = (case_mem[b+7][1:0] == op2_rs2) && !case_mem[b+12][0];
        tag1[r]  = case_mem[b+8][phy_reg_bits-1:0];
        tag2[r]  = case_mem[b+11][phy_reg_bits-1:0];
        lat_check[r]   = (outstanding == 0) && !wait1[r] && !wait2[r];
        accept_time[r] = $time;
        case_of_rob[r] = c;
        pending[r]     = 1'b1;
        outstanding++;
    endtask

    task automatic sample_cdb();
        int r;
        bit bad;
        if (cdb_valid === 1'b1) begin
            r   = cdb_rob_id;
            bad = 1'b0;
            if (!pending[r]) begin
                $display("CDB broadcast for rob id %0d, which is not outstanding", r);
                fail_count++;
            end else begin
                if (cdb_rd_value !== exp_value[r]) begin
                    $display("** Error at %0t: cdb_rd_value expected %h, got %h",
                             $time, exp_value[r], cdb_rd_value);
                    bad = 1'b1;
                end
                if (cdb_rd_arch !== exp_arch[r]) begin
                    $display("** Error at %0t: cdb_rd_arch expected %h, got %h",
                             $time, exp_arch[r], cdb_rd_arch);
                    bad = 1'b1;
                end
                if (cdb_rd_phy !== exp_phy[r]) begin
                    $display("** Error at %0t: cdb_rd_phy expected %h, got %h",
                             $time, exp_phy[r], cdb_rd_phy);
                    bad = 1'b1;
                end
                if ((wait1[r] && !phy_seen[tag1[r]]) || (wait2[r] && !phy_seen[tag2[r]])) begin
                    $display("rob id %0d was broadcast before its producer", r);
                    bad = 1'b1;
                end
                if (lat_check[r] && ($time - accept_time[r] != 3 * clk_period)) begin
                    $display("** Error at %0t: cdb_valid for rob id %0d expected at %0t, got %0t",
                             $time, r, accept_time[r] + 3 * clk_period, $time);
                    bad = 1'b1;
                end
                phy_seen[cdb_rd_phy] = 1'b1;
                pending[r] = 1'b0;
                outstanding--;
                report_test($sformatf("case %0d, rob id %0d", case_of_rob[r], r), bad);
            end
        end
    endtask

    task automatic check_reset_state();
        bit bad;
        bad = 1'b0;
        if (cdb_valid !== 1'b0) begin
            $display("** Error at %0t: cdb_valid expected 0, got %b", $time, cdb_valid);
            bad = 1'b1;
        end
        if (dispatch_ready !== 1'b1) begin
            $display("** Error at %0t: dispatch_ready expected 1, got %b", $time, dispatch_ready);
            bad = 1'b1;
        end
        report_test("reset state", bad);
    endtask

    initial begin
        int idle;
        int held;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        rob_id = '0;
        rd_arch = '0;
        rd_phy = '0;
        pc = '0;
        imm = '0;
        fu_opcode = alu_add;
        op1_sel = op1_rs1;
        op2_sel = op2_rs2;
        rs1_phy = '0;
        rs1_ready = 1'b0;
        rs1_value = '0;
        rs2_phy = '0;
        rs2_ready = 1'b0;
        rs2_value = '0;
        rng = 32'd39;
        outstanding = 0;
        pass_count = 0;
        fail_count = 0;
        stall_seen = 1'b0;
        full_bad = 1'b0;
        for (int i = 0; i < rob_count; i++) pending[i] = 1'b0;
        for (int i = 0; i < phy_count; i++) phy_seen[i] = 1'b0;

        $readmemh("tests/int_exec_cases.txt", case_mem);
        n_cases = 0;
        total_gap = 0;
        while (n_cases < max_cases && !$isunknown(case_mem[n_cases*case_words])) begin
            total_gap += case_mem[n_cases*case_words + 14];
            n_cases++;
        end
        watchdog_limit = longint'(n_cases + total_gap + 20) * 8 * clk_period;
        cases_loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        for (int c = 0; c < n_cases; c++) begin
            idle = case_mem[c*case_words + 14];
            if (idle != 0) begin // bursts with gap 0 stay back to back.
                rng = xorshift32(rng);
                idle = idle + int'(rng[1:0]);
            end
            repeat (idle) begin
                @(negedge clk);
                sample_cdb();
                dispatch_valid = 1'b0;
            end
            @(negedge clk);
            sample_cdb();
            drive_case(c);
            while (dispatch_ready !== 1'b1) begin
                stall_seen = 1'b1;
                held = outstanding;
                @(negedge clk);
                // a broadcast now was still in the alu stage.
                if (cdb_valid === 1'b1) held--;
                if (held != int_rs_depth) begin
                    $display("dispatch_ready was low with %0d micro-ops in the station",
                             held);
                    full_bad = 1'b1;
                end
                sample_cdb();
            end
            record_accept(c);
        end

        @(negedge clk);
        sample_cdb();
        dispatch_valid = 1'b0;
        while (outstanding > 0) begin
            @(negedge clk);
            sample_cdb();
        end
        repeat (4) begin // catch late duplicates.
            @(negedge clk);
            sample_cdb();
        end

        if (!stall_seen) begin
            $display("dispatch_ready never dropped, the station never filled");
            full_bad = 1'b1;
        end
        report_test("full station", full_bad);

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (cases_loaded);
        #(watchdog_limit);
        $display("timeout: run did not finish within %0d time units", watchdog_limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule
